/* logic/z8Pkg.sv */
package z8Pkg;

    localparam int DefaultAddrWidth = 16;
    localparam int DefaultRegDepth  = 128;
    localparam int RegAddrWidth     = 7;

    typedef logic [7:0]                  dataT;
    typedef logic [DefaultAddrWidth-1:0] addrT;
    typedef logic [RegAddrWidth-1:0]     regAddrT;
    typedef logic [3:0]                  nibbleT;
    // only the upper four bits hold flags
    typedef logic [7:0]                  flagsT;

    localparam int FlagC = 7;
    localparam int FlagZ = 6;
    localparam int FlagS = 5;
    localparam int FlagV = 4;

    // register-register codes equal the opcode high nibble
    typedef logic [3:0] aluOpT;
    localparam aluOpT AluAdd = 4'h0;
    localparam aluOpT AluAdc = 4'h1;
    localparam aluOpT AluSub = 4'h2;
    localparam aluOpT AluSbc = 4'h3;
    localparam aluOpT AluOr  = 4'h4;
    localparam aluOpT AluAnd = 4'h5;
    localparam aluOpT AluInc = 4'h6;
    localparam aluOpT AluDec = 4'h7;
    localparam aluOpT AluLd  = 4'h8;
    localparam aluOpT AluCp  = 4'hA;
    localparam aluOpT AluXor = 4'hB;

    // low nibble opcode columns
    localparam nibbleT ColRegReg = 4'h2;
    localparam nibbleT ColDjnz   = 4'hA;
    localparam nibbleT ColJr     = 4'hB;
    localparam nibbleT ColLdImm  = 4'hC;
    localparam nibbleT ColJp     = 4'hD;
    localparam nibbleT ColInc    = 4'hE;
    localparam nibbleT ColMisc   = 4'hF;

    localparam regAddrT Port2Reg = 7'd2;

endpackage

/* logic/fetchIf.sv */
`timescale 1ns/1ps

interface fetchIf;
    import z8Pkg::*;

    logic instrValid;
    dataT opcode;
    dataT second;
    dataT third;
    addrT nextPc;
    logic instrReady;
    logic redirect;
    addrT target;

    modport fetch (output instrValid, opcode, second, third, nextPc,
                   input  instrReady, redirect, target);
    modport exec  (input  instrValid, opcode, second, third, nextPc,
                   output instrReady, redirect, target);
endinterface

/* logic/regPortIf.sv */
`timescale 1ns/1ps

interface regPortIf;
    import z8Pkg::*;

    regAddrT rdAddrA;
    regAddrT rdAddrB;
    dataT    rdDataA;
    dataT    rdDataB;
    logic    wrEn;
    regAddrT wrAddr;
    dataT    wrData;

    modport ctrl (output rdAddrA, rdAddrB, wrEn, wrAddr, wrData,
                  input  rdDataA, rdDataB);
    modport regs (input  rdAddrA, rdAddrB, wrEn, wrAddr, wrData,
                  output rdDataA, rdDataB);
endinterface

/* logic/instrFetch.sv */
`timescale 1ns/1ps

module instrFetch #(
    parameter int AddrWidth = z8Pkg::DefaultAddrWidth
) (
    input  logic                 clk,
    input  logic                 reset,
    output logic [AddrWidth-1:0] memAddr,
    output logic                 memValid,
    input  logic                 memReady,
    input  z8Pkg::dataT          memData,
    input  logic                 memDataValid,
    fetchIf.fetch                fetch
);
    import z8Pkg::*;

    logic [AddrWidth-1:0] pc;
    logic [1:0]           byteIdx;
    logic                 outstanding;
    logic                 dropPending;
    logic                 instrValid;
    dataT                 opcode;
    dataT                 second;
    dataT                 third;
    dataT                 curOpcode;
    logic                 accept;
    logic                 issue;
    logic                 useByte;

    // index of the last byte of an instruction
    function automatic logic [1:0] lastByte(dataT op);
        case (op[3:0])
            ColInc, ColMisc: lastByte = 2'd0;
            ColJp:           lastByte = 2'd2;
            default:         lastByte = 2'd1;
        endcase
    endfunction

    assign accept    = instrValid && fetch.instrReady;
    assign issue     = !fetch.redirect && !memValid && !outstanding && (!instrValid || accept);
    assign useByte   = memDataValid && !dropPending && !fetch.redirect;
    assign curOpcode = (byteIdx == 2'd0) ? memData : opcode;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= '0;
            memValid    <= 1'b0;
            outstanding <= 1'b0;
            dropPending <= 1'b0;
            instrValid  <= 1'b0;
            byteIdx     <= 2'd0;
        end else begin
            if (memValid && memReady) begin
                memValid    <= 1'b0;
                outstanding <= 1'b1;
            end else if (memDataValid) begin
                outstanding <= 1'b0;
            end
            if (memDataValid && dropPending) begin
                dropPending <= 1'b0;
            end
            if (issue) begin
                memValid <= 1'b1;
                pc       <= pc + 1'b1;
            end
            if (accept) begin
                instrValid <= 1'b0;
            end
            if (useByte) begin
                if (byteIdx == lastByte(curOpcode)) begin
                    instrValid <= 1'b1;
                    byteIdx    <= 2'd0;
                end else begin
                    byteIdx <= byteIdx + 2'd1;
                end
            end
            // a request already on the bus still completes, its byte is dropped
            if (fetch.redirect) begin
                pc          <= AddrWidth'(fetch.target);
                instrValid  <= 1'b0;
                byteIdx     <= 2'd0;
                dropPending <= memValid || (outstanding && !memDataValid);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            memAddr <= pc;
        end
        if (useByte) begin
            case (byteIdx)
                2'd0:    opcode <= memData;
                2'd1:    second <= memData;
                default: third  <= memData;
            endcase
        end
    end

    assign fetch.instrValid = instrValid;
    assign fetch.opcode     = opcode;
    assign fetch.second     = second;
    assign fetch.third      = third;
    // pc already points past a held instruction
    assign fetch.nextPc     = addrT'(pc);

endmodule

/* logic/execControl.sv */
`timescale 1ns/1ps

module execControl (
    input  logic           clk,
    input  logic           reset,
    fetchIf.exec           fetch,
    regPortIf.ctrl         regs,
    output z8Pkg::aluOpT   aluOp,
    output z8Pkg::dataT    aluA,
    output z8Pkg::dataT    aluB,
    output logic           aluCarry,
    input  z8Pkg::dataT    aluResult,
    input  z8Pkg::flagsT   aluFlags
);
    import z8Pkg::*;

    typedef enum logic {Decode, Execute} stateT;

    stateT  state;
    stateT  nextState;
    flagsT  flags;
    logic   flagsWrite;
    dataT   opcodeReg;
    dataT   secondReg;
    addrT   nextPcReg;
    dataT   curOp;
    dataT   curSecond;
    nibbleT opHigh;
    nibbleT opLow;
    nibbleT workReg;
    logic   decodeNow;
    logic   condBase;
    logic   condTrue;
    addrT   relBase;
    addrT   relTarget;

    function automatic logic aluColumnOp(nibbleT hi);
        case (hi)
            AluAdd, AluAdc, AluSub, AluSbc, AluOr, AluAnd, AluCp, AluXor: aluColumnOp = 1'b1;
            default: aluColumnOp = 1'b0;
        endcase
    endfunction

    // fields come from the fetch bus in Decode, from the latch in Execute
    assign curOp     = (state == Decode) ? fetch.opcode : opcodeReg;
    assign curSecond = (state == Decode) ? fetch.second : secondReg;
    assign opHigh    = curOp[7:4];
    assign opLow     = curOp[3:0];
    assign decodeNow = (state == Decode) && fetch.instrValid;

    always_comb begin
        case (opHigh[2:0])
            3'd0:    condBase = 1'b0;
            3'd1:    condBase = flags[FlagS] ^ flags[FlagV];
            3'd2:    condBase = (flags[FlagS] ^ flags[FlagV]) | flags[FlagZ];
            3'd3:    condBase = flags[FlagC] | flags[FlagZ];
            3'd4:    condBase = flags[FlagV];
            3'd5:    condBase = flags[FlagS];
            3'd6:    condBase = flags[FlagZ];
            default: condBase = flags[FlagC];
        endcase
    end
    assign condTrue = condBase ^ opHigh[3];

    // destination is the high nibble of the second byte for reg-reg ops
    assign workReg      = (opLow == ColRegReg) ? curSecond[7:4] : opHigh;
    assign regs.rdAddrA = regAddrT'(workReg);
    assign regs.rdAddrB = regAddrT'(curSecond[3:0]);
    assign regs.wrAddr  = regAddrT'(workReg);
    assign regs.wrData  = aluResult;
    assign aluCarry     = flags[FlagC];

    assign relBase      = (state == Decode) ? fetch.nextPc : nextPcReg;
    assign relTarget    = relBase + {{(DefaultAddrWidth - 8){curSecond[7]}}, curSecond};
    assign fetch.target = (state == Decode && opLow == ColJp) ?
                          addrT'({curSecond, fetch.third}) : relTarget;
    assign fetch.instrReady = (state == Decode);

    always_comb begin
        aluOp          = AluLd;
        aluA           = regs.rdDataA;
        aluB           = curSecond;
        regs.wrEn      = 1'b0;
        flagsWrite     = 1'b0;
        fetch.redirect = 1'b0;
        nextState      = state;
        case (state)
            Decode: begin
                if (fetch.instrValid) begin
                    case (opLow)
                        ColRegReg: begin
                            if (aluColumnOp(opHigh)) begin
                                nextState = Execute;
                            end
                        end
                        ColDjnz:  nextState = Execute;
                        ColJr:    fetch.redirect = condTrue;
                        ColJp:    fetch.redirect = condTrue;
                        ColLdImm: regs.wrEn = 1'b1;
                        ColInc: begin
                            aluOp      = AluInc;
                            regs.wrEn  = 1'b1;
                            flagsWrite = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
            Execute: begin
                flagsWrite = 1'b1;
                nextState  = Decode;
                if (opLow == ColDjnz) begin
                    aluOp          = AluDec;
                    regs.wrEn      = 1'b1;
                    fetch.redirect = (aluResult != 8'h00);
                end else begin
                    aluOp     = aluOpT'(opHigh);
                    aluB      = regs.rdDataB;
                    regs.wrEn = (opHigh != AluCp);
                end
            end
            default: nextState = Decode;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Decode;
            flags <= '0;
        end else begin
            state <= nextState;
            if (flagsWrite) begin
                flags <= aluFlags;
            end else if (decodeNow && opLow == ColMisc) begin
                // rcf, scf, ccf; the rest of the column acts as nop
                case (opHigh)
                    4'hC:    flags[FlagC] <= 1'b0;
                    4'hD:    flags[FlagC] <= 1'b1;
                    4'hE:    flags[FlagC] <= ~flags[FlagC];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decodeNow) begin
            opcodeReg <= fetch.opcode;
            secondReg <= fetch.second;
            nextPcReg <= fetch.nextPc;
        end
    end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  z8Pkg::aluOpT op,
    input  z8Pkg::dataT  a,
    input  z8Pkg::dataT  b,
    input  logic         carryIn,
    output z8Pkg::dataT  result,
    output z8Pkg::flagsT flags
);
    import z8Pkg::*;

    logic       cin;
    logic [8:0] sum;
    logic [8:0] diff;
    logic       carry;
    logic       overflow;

    assign cin  = (op == AluAdc || op == AluSbc) ? carryIn : 1'b0;
    assign sum  = {1'b0, a} + {1'b0, b} + {8'h00, cin};
    // bit 8 set on borrow
    assign diff = {1'b0, a} - {1'b0, b} - {8'h00, cin};

    always_comb begin
        result   = b;
        carry    = carryIn;
        overflow = 1'b0;
        case (op)
            AluAdd, AluAdc: begin
                result   = sum[7:0];
                carry    = sum[8];
                overflow = (a[7] == b[7]) && (sum[7] != a[7]);
            end
            AluSub, AluSbc, AluCp: begin
                result   = diff[7:0];
                carry    = diff[8];
                overflow = (a[7] != b[7]) && (diff[7] != a[7]);
            end
            AluOr:  result = a | b;
            AluAnd: result = a & b;
            AluXor: result = a ^ b;
            AluInc: begin
                result   = a + 8'h01;
                overflow = (a == 8'h7F);
            end
            AluDec: begin
                result   = a - 8'h01;
                overflow = (a == 8'h80);
            end
            AluLd:   result = b;
            default: result = b;
        endcase
        flags        = '0;
        flags[FlagC] = carry;
        flags[FlagZ] = (result == 8'h00);
        flags[FlagS] = result[7];
        flags[FlagV] = overflow;
    end

endmodule

/* logic/registerFile.sv */
`timescale 1ns/1ps

module registerFile #(
    parameter int RegDepth = z8Pkg::DefaultRegDepth
) (
    input  logic        clk,
    input  logic        reset,
    regPortIf.regs      regs,
    output z8Pkg::dataT port2
);
    import z8Pkg::*;

    dataT regArray [RegDepth];

    assign regs.rdDataA = regArray[regs.rdAddrA];
    assign regs.rdDataB = regArray[regs.rdAddrB];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RegDepth; i++) begin
                regArray[i] <= '0;
            end
            port2 <= '0;
        end else if (regs.wrEn) begin
            regArray[regs.wrAddr] <= regs.wrData;
            // port 2 mirrors register 2
            if (regs.wrAddr == Port2Reg) begin
                port2 <= regs.wrData;
            end
        end
    end

endmodule

/* logic/z8Core.sv */
`timescale 1ns/1ps

module z8Core #(
    parameter int AddrWidth = z8Pkg::DefaultAddrWidth,
    parameter int RegDepth  = z8Pkg::DefaultRegDepth
) (
    input  logic                 clk,
    input  logic                 reset,
    output logic [AddrWidth-1:0] memAddr,
    output logic                 memValid,
    input  logic                 memReady,
    input  z8Pkg::dataT          memData,
    input  logic                 memDataValid,
    output z8Pkg::dataT          port2
);
    import z8Pkg::*;

    aluOpT aluOp;
    dataT  aluA;
    dataT  aluB;
    logic  aluCarry;
    dataT  aluResult;
    flagsT aluFlags;

    fetchIf   fetchBus ();
    regPortIf regBus ();

    instrFetch #(
        .AddrWidth(AddrWidth)
    ) fetchUnit (
        .clk         (clk),
        .reset       (reset),
        .memAddr     (memAddr),
        .memValid    (memValid),
        .memReady    (memReady),
        .memData     (memData),
        .memDataValid(memDataValid),
        .fetch       (fetchBus.fetch)
    );

    execControl execUnit (
        .clk      (clk),
        .reset    (reset),
        .fetch    (fetchBus.exec),
        .regs     (regBus.ctrl),
        .aluOp    (aluOp),
        .aluA     (aluA),
        .aluB     (aluB),
        .aluCarry (aluCarry),
        .aluResult(aluResult),
        .aluFlags (aluFlags)
    );

    alu aluUnit (
        .op     (aluOp),
        .a      (aluA),
        .b      (aluB),
        .carryIn(aluCarry),
        .result (aluResult),
        .flags  (aluFlags)
    );

    registerFile #(
        .RegDepth(RegDepth)
    ) regFile (
        .clk  (clk),
        .reset(reset),
        .regs (regBus.regs),
        .port2(port2)
    );

endmodule

/* testbench/z8Core_assert.sv */
`timescale 1ns/1ps

module z8CoreAssert #(
    parameter int AddrWidth = z8Pkg::DefaultAddrWidth
) (
    input logic                 clk,
    input logic                 reset,
    input logic [AddrWidth-1:0] memAddr,
    input logic                 memValid,
    input logic                 memReady,
    input logic                 memDataValid,
    input logic                 instrValid,
    input logic                 instrReady,
    input logic                 redirect
);
    int   failCount = 0;
    logic outstanding;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (memValid && memReady) begin
            outstanding <= 1'b1;
        end else if (memDataValid) begin
            outstanding <= 1'b0;
        end
    end

    addrHeld: assert property (@(posedge clk) disable iff (reset)
        memValid && !memReady |=> memValid && $stable(memAddr))
    else begin
        failCount++;
        $error("memory request changed before memReady");
    end

    responseExpected: assert property (@(posedge clk) disable iff (reset)
        memDataValid |-> outstanding)
    else begin
        failCount++;
        $error("memDataValid without an outstanding request");
    end

    // a redirect may drop a held instruction
    instrHeld: assert property (@(posedge clk) disable iff (reset)
        instrValid && !instrReady && !redirect |=> instrValid)
    else begin
        failCount++;
        $error("instrValid dropped before instrReady");
    end

endmodule

bind z8Core z8CoreAssert #(
    .AddrWidth(AddrWidth)
) coreChecks (
    .clk         (clk),
    .reset       (reset),
    .memAddr     (memAddr),
    .memValid    (memValid),
    .memReady    (memReady),
    .memDataValid(memDataValid),
    .instrValid  (fetchBus.instrValid),
    .instrReady  (fetchBus.instrReady),
    .redirect    (fetchBus.redirect)
);

/* testbench/z8CoreTb.sv */
`timescale 1ns/1ps

module z8CoreTb;
    import z8Pkg::*;

    localparam int AddrWidth      = 16;
    localparam int RegDepth       = 128;
    localparam int VecDepth       = 256;
    localparam int CyclesPerByte  = 200;
    localparam int CyclesPerValue = 100;
    // quiet time after the last value, to catch stray port2 writes
    localparam int DrainCycles    = 300;

    logic                 clk;
    logic                 reset;
    logic [AddrWidth-1:0] memAddr;
    logic                 memValid;
    logic                 memReady;
    dataT                 memData;
    logic                 memDataValid;
    dataT                 port2;

    dataT                 vectors [VecDepth];
    dataT                 progMem [VecDepth];
    dataT                 expected [$];
    int                   progLen;
    int                   expCount;
    int                   seenCount;
    int                   errorCount;
    int                   cycleCount;
    int                   cycleLimit;
    integer               seed;
    dataT                 lastPort2;

    // memory model state
    logic                 respBusy;
    int                   respWait;
    logic [AddrWidth-1:0] respAddr;
    logic                 stall;

    z8Core #(
        .AddrWidth(AddrWidth),
        .RegDepth (RegDepth)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .memAddr     (memAddr),
        .memValid    (memValid),
        .memReady    (memReady),
        .memData     (memData),
        .memDataValid(memDataValid),
        .port2       (port2)
    );

    always #5 clk = ~clk;

    task automatic compareByte(input dataT actual, input dataT expectedValue, input string what);
        if (actual !== expectedValue) begin
            errorCount++;
            $display("mismatch at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expectedValue);
        end
    endtask

    task automatic loadVectors();
        $readmemh("testbench/z8_vectors.txt", vectors);
        progLen = vectors[0];
        for (int i = 0; i < progLen; i++) begin
            progMem[i] = vectors[1 + i];
        end
        expCount = vectors[progLen + 1];
        for (int i = 0; i < expCount; i++) begin
            expected.push_back(vectors[progLen + 2 + i]);
        end
    endtask

    // nop past the end of the program
    function automatic dataT programByte(input logic [AddrWidth-1:0] addr);
        if (addr < progLen) begin
            programByte = progMem[addr];
        end else begin
            programByte = 8'hFF;
        end
    endfunction

    // transfer seen at the edge, response and stall driven 1 ns later
    always @(posedge clk) begin
        if (memDataValid) begin
            respBusy = 1'b0;
        end
        if (memValid && memReady) begin
            respBusy = 1'b1;
            respAddr = memAddr;
            respWait = $random(seed) & 3;
        end else if (respBusy && respWait > 0) begin
            respWait--;
        end
        stall = (($random(seed) & 3) == 0);
        #1;
        memReady     = !stall;
        memDataValid = respBusy && (respWait == 0);
        memData      = memDataValid ? programByte(respAddr) : 8'h00;
    end

    always @(posedge clk) begin
        if (!reset && port2 !== lastPort2) begin
            if (seenCount < expCount) begin
                compareByte(port2, expected[seenCount],
                            $sformatf("port2 value %0d", seenCount));
            end else begin
                errorCount++;
                $display("port2 changed to %h after the last expected value", port2);
            end
            seenCount++;
            lastPort2 = port2;
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        memReady     = 1'b0;
        memData      = '0;
        memDataValid = 1'b0;
        seed         = 32'h7eef_281a;
        respBusy     = 1'b0;
        respWait     = 0;
        respAddr     = '0;
        stall        = 1'b0;
        errorCount   = 0;
        seenCount    = 0;
        cycleCount   = 0;
        lastPort2    = '0;
        loadVectors();
        if (progLen == 0 || expCount == 0) begin
            errorCount++;
            $display("the vector file is missing or holds no program or no expected values");
        end
        cycleLimit = CyclesPerByte * progLen + CyclesPerValue * expCount;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // falling edge, so the port2 monitor has already run
        while (seenCount < expCount && cycleCount < cycleLimit) begin
            @(negedge clk);
            cycleCount++;
        end
        if (seenCount < expCount) begin
            errorCount++;
            $display("timeout: the program did not finish within %0d cycles", cycleLimit);
            $display("only %0d of %0d port2 values were seen", seenCount, expCount);
        end else begin
            repeat (DrainCycles) @(negedge clk);
        end
        errorCount += uut.coreChecks.failCount;
        $display("port2 values seen: %0d, errors: %0d", seenCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* z8Core.f */
logic/z8Pkg.sv
logic/fetchIf.sv
logic/regPortIf.sv
logic/instrFetch.sv
logic/execControl.sv
logic/alu.sv
logic/registerFile.sv
logic/z8Core.sv
testbench/z8Core_assert.sv
testbench/z8CoreTb.sv

/* testbench/z8_vectors.txt */
// program byte count, program bytes from address 0,
// expected port2 count, expected port2 values in order
B0
// ld r2,# with four values
2C 11 2C 22 2C 33 2C A5
// ALU column with scf, rcf, ccf and cp changing the carry
3C 14 4C 27 2C 05 02 23 12 24 DF 12 23
22 24 32 23 DF 32 24 CF 12 23 EF 12 24
A2 32 12 23 42 23 52 24 B2 23
// inc past FF, add that overflows, then adc
2C FE 2E 2E 5C F0 2C 30 02 25 12 25 12 23
// djnz loop of three passes, each inc r2
6C 03 2E 6A FD 2C 40
// jr on z, c, s and v, taken and not taken
6B 02 2C EE 2C 41 EB 02 2C 42 7B 02 2C 43 FB 02 2C EE 2C 44
7C 70 A2 75 5B 02 2C EE 2C 45 DB 02 2C 46
4B 02 2C EE 2C 47 CB 02 2C 48
// jr and jp on combined conditions
1B 02 2C 49 9D 00 76 2C EE 2C 4A 3D 00 7D 2C EE 2C 4B
BD 00 84 2C 4C AD 00 89 2C EE 2C 4D 2D 00 90 2C 4E
0D 00 95 2C 4F 8D 00 9A 2C EE 2C 50
// jp on c and z after rcf, then jr to itself
CF 7D 00 A2 2C 51 6D 00 A7 2C 52 ED 00 AC 2C EE 2C 53 8B FE
2F
11 22 33 A5
05 19 40 55 2E 1A F2 06 2D 42 56 06 12
FE FF 00 30 20 11 26
27 28 29 40
41 42 43 44 45 46 47 48 49 4A 4B 4C 4D 4E 4F 50 51 52 53
